/* build.f */
+incdir+rtl
+incdir+verification
rtl/rv_isa_pkg.sv
rtl/ds_ctrl_pkg.sv
rtl/gpr_file.sv
rtl/branch_unit.sv
rtl/inst_decoder.sv
rtl/ds_stage_ctrl.sv
rtl/id_stage.sv
verification/tb_id_stage.sv

/* rtl/branch_unit.sv */
// branch condition evaluation and jump/branch target adder
`timescale 1ns/1ps
`default_nettype none
`include "ds_params.svh"

module branch_unit (
  input  logic [`XLEN-1:0] i_pc,
  input  logic [`XLEN-1:0] i_rs1_data,
  input  logic [`XLEN-1:0] i_rs2_data,
  input  logic [`XLEN-1:0] i_imm,
  input  logic [2:0]       i_funct3,
  input  logic             i_is_branch,
  input  logic             i_is_jal,
  input  logic             i_is_jalr,
  output logic             o_br_cond,
  output logic [`XLEN-1:0] o_br_target
);

  import rv_isa_pkg::*;

  logic             eq;
  logic             lt;
  logic             ltu;
  logic             cmp;
  logic [`XLEN-1:0] base;
  logic [`XLEN-1:0] sum;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_funct3)
      F3_BEQ:  cmp = eq;
      F3_BNE:  cmp = !eq;
      F3_BLT:  cmp = lt;
      F3_BGE:  cmp = !lt;
      F3_BLTU: cmp = ltu;
      F3_BGEU: cmp = !ltu;
      default: cmp = 1'b0; // 010/011 not branches
    endcase
  end

  assign o_br_cond = i_is_jal || i_is_jalr || (i_is_branch && cmp);

  assign base        = i_is_jalr ? i_rs1_data : i_pc;
  assign sum         = base + i_imm;
  assign o_br_target = i_is_jalr ? {sum[`XLEN-1:1], 1'b0} : sum; // jalr clears bit 0

endmodule

`default_nettype wire

/* rtl/ds_ctrl_pkg.sv */
// alu operation, operand select and memory op types sent to execute
`default_nettype none

package ds_ctrl_pkg;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_t;

  typedef enum logic {
    SRC1_RS1 = 1'b0,
    SRC1_PC  = 1'b1
  } src1_sel_t;

  typedef enum logic [1:0] {
    SRC2_RS2  = 2'd0,
    SRC2_IMM  = 2'd1,
    SRC2_FOUR = 2'd2 // link address for jumps
  } src2_sel_t;

  typedef logic [2:0] mem_op_t; // funct3 of the load/store

endpackage

`default_nettype wire

/* rtl/ds_params.svh */
// data, instruction, register-address and register-count width macros
`ifndef DS_PARAMS_SVH
`define DS_PARAMS_SVH

`define XLEN    64 // data and pc width
`define INST_W  32
`define GPR_AW  5
`define GPR_NUM 32

`endif

/* rtl/ds_stage_ctrl.sv */
// stage valid/allowin control, instruction and pc register, raw interlock, redirect gating
`timescale 1ns/1ps
`default_nettype none
`include "ds_params.svh"

module ds_stage_ctrl (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_fs_to_ds_valid,
  input  logic [`INST_W-1:0] i_fs_inst,
  input  logic [`XLEN-1:0]   i_fs_pc,
  input  logic               i_es_allowin,
  input  logic [`GPR_AW-1:0] i_rs1,
  input  logic [`GPR_AW-1:0] i_rs2,
  input  logic               i_rs1_used,
  input  logic               i_rs2_used,
  input  logic [`GPR_AW-1:0] i_es_gpr_rd,
  input  logic [`GPR_AW-1:0] i_ms_gpr_rd,
  input  logic [`GPR_AW-1:0] i_ws_gpr_rd,
  input  logic               i_br_cond,
  output logic               o_ds_allowin,
  output logic               o_ds_to_es_valid,
  output rv_isa_pkg::inst_u  o_inst,
  output logic [`XLEN-1:0]   o_pc,
  output logic               o_br_taken
);

  logic ds_valid;
  logic rs1_hit;
  logic rs2_hit;
  logic hazard;
  logic ds_ready_go;

  // source waits on any later stage still writing it
  assign rs1_hit = i_rs1_used && (i_rs1 != '0) &&
                   (i_rs1 == i_es_gpr_rd || i_rs1 == i_ms_gpr_rd || i_rs1 == i_ws_gpr_rd);
  assign rs2_hit = i_rs2_used && (i_rs2 != '0) &&
                   (i_rs2 == i_es_gpr_rd || i_rs2 == i_ms_gpr_rd || i_rs2 == i_ws_gpr_rd);
  assign hazard      = rs1_hit || rs2_hit;
  assign ds_ready_go = !hazard;

  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;
  assign o_br_taken       = o_ds_to_es_valid && i_es_allowin && i_br_cond; // only as it leaves

  // hold / load / squash
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid && !o_br_taken; // drop the fall-through word
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_inst <= '0;
      o_pc   <= '0;
    end else if (i_fs_to_ds_valid && o_ds_allowin) begin
      o_inst <= i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

  // stage empty right after a taken redirect
  a_squash_empties: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_br_taken |=> !ds_valid
  );

  // held until execute takes it
  a_hold_until_taken: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (ds_valid && !(o_ds_to_es_valid && i_es_allowin))
      |=> (ds_valid && $stable(o_inst) && $stable(o_pc))
  );

endmodule

`default_nettype wire

/* rtl/gpr_file.sv */
// 32 x 64-bit general register file, two async reads, one write port
`timescale 1ns/1ps
`default_nettype none
`include "ds_params.svh"

module gpr_file (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic [`GPR_AW-1:0] i_raddr1,
  input  logic [`GPR_AW-1:0] i_raddr2,
  input  logic               i_wen,
  input  logic [`GPR_AW-1:0] i_waddr,
  input  logic [`XLEN-1:0]   i_wdata,
  output logic [`XLEN-1:0]   o_rdata1,
  output logic [`XLEN-1:0]   o_rdata2
);

  logic [`XLEN-1:0] regs [`GPR_NUM];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `GPR_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin // x0 stays zero
      regs[i_waddr] <= i_wdata;
    end
  end

  // no bypass, interlock covers write-back
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

/* rtl/id_stage.sv */
// instruction-decode stage top level
`timescale 1ns/1ps
`default_nettype none
`include "ds_params.svh"

module id_stage (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  // fetch side
  input  logic                   i_fs_to_ds_valid,
  input  logic [`INST_W-1:0]     i_fs_inst,
  input  logic [`XLEN-1:0]       i_fs_pc,
  output logic                   o_ds_allowin,
  // execute side
  input  logic                   i_es_allowin,
  output logic                   o_ds_to_es_valid,
  output logic [`XLEN-1:0]       o_pc,
  output logic [`XLEN-1:0]       o_rs1_data,
  output logic [`XLEN-1:0]       o_rs2_data,
  output logic [`XLEN-1:0]       o_imm,
  output logic [`GPR_AW-1:0]     o_rd,
  output ds_ctrl_pkg::alu_op_t   o_alu_op,
  output ds_ctrl_pkg::src1_sel_t o_alu_src1_sel,
  output ds_ctrl_pkg::src2_sel_t o_alu_src2_sel,
  output logic                   o_alu_word,
  output logic                   o_gpr_wen,
  output logic                   o_mem_ren,
  output logic                   o_mem_wen,
  output ds_ctrl_pkg::mem_op_t   o_mem_op,
  output logic                   o_invalid_inst,
  // redirect to fetch
  output logic                   o_br_taken,
  output logic [`XLEN-1:0]       o_br_target,
  // write-back port
  input  logic                   i_wb_gpr_wen,
  input  logic [`GPR_AW-1:0]     i_wb_gpr_waddr,
  input  logic [`XLEN-1:0]       i_wb_gpr_wdata,
  // destinations still in flight
  input  logic [`GPR_AW-1:0]     i_es_gpr_rd,
  input  logic [`GPR_AW-1:0]     i_ms_gpr_rd,
  input  logic [`GPR_AW-1:0]     i_ws_gpr_rd
);

  import rv_isa_pkg::*;

  inst_u              ds_inst;
  logic [`GPR_AW-1:0] rs1;
  logic [`GPR_AW-1:0] rs2;
  logic               rs1_used;
  logic               rs2_used;
  logic               is_branch;
  logic               is_jal;
  logic               is_jalr;
  logic               br_cond;

  ds_stage_ctrl u_ctrl (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_rs1            (rs1),
    .i_rs2            (rs2),
    .i_rs1_used       (rs1_used),
    .i_rs2_used       (rs2_used),
    .i_es_gpr_rd      (i_es_gpr_rd),
    .i_ms_gpr_rd      (i_ms_gpr_rd),
    .i_ws_gpr_rd      (i_ws_gpr_rd),
    .i_br_cond        (br_cond),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_inst           (ds_inst),
    .o_pc             (o_pc),
    .o_br_taken       (o_br_taken)
  );

  inst_decoder u_dec (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rs1_used     (rs1_used),
    .o_rs2_used     (rs2_used),
    .o_rd           (o_rd),
    .o_imm          (o_imm),
    .o_alu_op       (o_alu_op),
    .o_alu_src1_sel (o_alu_src1_sel),
    .o_alu_src2_sel (o_alu_src2_sel),
    .o_alu_word     (o_alu_word),
    .o_gpr_wen      (o_gpr_wen),
    .o_mem_ren      (o_mem_ren),
    .o_mem_wen      (o_mem_wen),
    .o_mem_op       (o_mem_op),
    .o_is_branch    (is_branch),
    .o_is_jal       (is_jal),
    .o_is_jalr      (is_jalr),
    .o_invalid_inst (o_invalid_inst)
  );

  gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wen    (i_wb_gpr_wen),
    .i_waddr  (i_wb_gpr_waddr),
    .i_wdata  (i_wb_gpr_wdata),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

  branch_unit u_bru (
    .i_pc        (o_pc),
    .i_rs1_data  (o_rs1_data),
    .i_rs2_data  (o_rs2_data),
    .i_imm       (o_imm),
    .i_funct3    (ds_inst.b_fmt.funct3),
    .i_is_branch (is_branch),
    .i_is_jal    (is_jal),
    .i_is_jalr   (is_jalr),
    .o_br_cond   (br_cond),
    .o_br_target (o_br_target)
  );

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
// rv64i instruction decoder: register fields, immediate, alu and memory controls
`timescale 1ns/1ps
`default_nettype none
`include "ds_params.svh"

module inst_decoder (
  input  rv_isa_pkg::inst_u      i_inst,
  output logic [`GPR_AW-1:0]     o_rs1,
  output logic [`GPR_AW-1:0]     o_rs2,
  output logic                   o_rs1_used,
  output logic                   o_rs2_used,
  output logic [`GPR_AW-1:0]     o_rd,
  output logic [`XLEN-1:0]       o_imm,
  output ds_ctrl_pkg::alu_op_t   o_alu_op,
  output ds_ctrl_pkg::src1_sel_t o_alu_src1_sel,
  output ds_ctrl_pkg::src2_sel_t o_alu_src2_sel,
  output logic                   o_alu_word,
  output logic                   o_gpr_wen,
  output logic                   o_mem_ren,
  output logic                   o_mem_wen,
  output ds_ctrl_pkg::mem_op_t   o_mem_op,
  output logic                   o_is_branch,
  output logic                   o_is_jal,
  output logic                   o_is_jalr,
  output logic                   o_invalid_inst
);

  import rv_isa_pkg::*;
  import ds_ctrl_pkg::*;

  opcode_t          opc;
  logic             alt; // inst[30], sub / sra
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;

  function automatic alu_op_t f3_to_alu(input logic [2:0] f3, input logic f7_alt,
                                        input logic reg_op);
    alu_op_t op;
    case (f3)
      3'b000:  op = (reg_op && f7_alt) ? ALU_SUB : ALU_ADD; // no subi
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = f7_alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opc = opcode_t'(i_inst.r_fmt.opcode);
  assign alt = i_inst.r_fmt.funct7[5];

  assign imm_i = {{(`XLEN-12){i_inst.i_fmt.imm[11]}}, i_inst.i_fmt.imm};
  assign imm_s = {{(`XLEN-12){i_inst.s_fmt.imm_11_5[6]}},
                  i_inst.s_fmt.imm_11_5, i_inst.s_fmt.imm_4_0};
  assign imm_b = {{(`XLEN-13){i_inst.b_fmt.imm_12}}, i_inst.b_fmt.imm_12, i_inst.b_fmt.imm_11,
                  i_inst.b_fmt.imm_10_5, i_inst.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {{(`XLEN-32){i_inst.u_fmt.imm_31_12[19]}}, i_inst.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{(`XLEN-21){i_inst.j_fmt.imm_20}}, i_inst.j_fmt.imm_20,
                  i_inst.j_fmt.imm_19_12, i_inst.j_fmt.imm_11, i_inst.j_fmt.imm_10_1, 1'b0};

  // unused sources read x0 so lui adds zero
  assign o_rs1 = o_rs1_used ? i_inst.r_fmt.rs1 : '0;
  assign o_rs2 = o_rs2_used ? i_inst.r_fmt.rs2 : '0;
  assign o_rd  = o_gpr_wen ? i_inst.r_fmt.rd : '0;

  always_comb begin
    o_rs1_used     = 1'b0;
    o_rs2_used     = 1'b0;
    o_imm          = '0;
    o_alu_op       = ALU_ADD;
    o_alu_src1_sel = SRC1_RS1;
    o_alu_src2_sel = SRC2_RS2;
    o_alu_word     = 1'b0;
    o_gpr_wen      = 1'b0;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_mem_op       = F3_MEM_B;
    o_is_branch    = 1'b0;
    o_is_jal       = 1'b0;
    o_is_jalr      = 1'b0;
    o_invalid_inst = 1'b0;
    case (opc)
      OPC_LUI: begin
        o_imm          = imm_u;
        o_alu_src2_sel = SRC2_IMM;
        o_gpr_wen      = 1'b1;
      end
      OPC_AUIPC: begin
        o_imm          = imm_u;
        o_alu_src1_sel = SRC1_PC;
        o_alu_src2_sel = SRC2_IMM;
        o_gpr_wen      = 1'b1;
      end
      OPC_JAL: begin
        o_imm          = imm_j;
        o_alu_src1_sel = SRC1_PC; // rd = pc + 4
        o_alu_src2_sel = SRC2_FOUR;
        o_gpr_wen      = 1'b1;
        o_is_jal       = 1'b1;
      end
      OPC_JALR: begin
        o_rs1_used     = 1'b1;
        o_imm          = imm_i;
        o_alu_src1_sel = SRC1_PC;
        o_alu_src2_sel = SRC2_FOUR;
        o_gpr_wen      = 1'b1;
        o_is_jalr      = 1'b1;
      end
      OPC_BRANCH: begin
        o_rs1_used  = 1'b1;
        o_rs2_used  = 1'b1;
        o_imm       = imm_b;
        o_is_branch = 1'b1;
      end
      OPC_LOAD: begin
        o_rs1_used     = 1'b1;
        o_imm          = imm_i;
        o_alu_src2_sel = SRC2_IMM;
        o_gpr_wen      = 1'b1;
        o_mem_ren      = 1'b1;
        o_mem_op       = i_inst.i_fmt.funct3;
      end
      OPC_STORE: begin
        o_rs1_used     = 1'b1;
        o_rs2_used     = 1'b1; // store data
        o_imm          = imm_s;
        o_alu_src2_sel = SRC2_IMM;
        o_mem_wen      = 1'b1;
        o_mem_op       = i_inst.s_fmt.funct3;
      end
      OPC_OP_IMM, OPC_OP_IMM_32: begin
        o_rs1_used     = 1'b1;
        o_imm          = imm_i;
        o_alu_op       = f3_to_alu(i_inst.i_fmt.funct3, alt, 1'b0);
        o_alu_src2_sel = SRC2_IMM;
        o_alu_word     = (opc == OPC_OP_IMM_32);
        o_gpr_wen      = 1'b1;
      end
      OPC_OP, OPC_OP_32: begin
        o_rs1_used = 1'b1;
        o_rs2_used = 1'b1;
        o_alu_op   = f3_to_alu(i_inst.r_fmt.funct3, alt, 1'b1);
        o_alu_word = (opc == OPC_OP_32);
        o_gpr_wen  = 1'b1;
      end
      default: o_invalid_inst = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/rv_isa_pkg.sv */
// rv64i opcode enumeration, funct3 names and instruction format union
`default_nettype none

package rv_isa_pkg;

  typedef enum logic [6:0] {
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_JAL       = 7'b1101111,
    OPC_JALR      = 7'b1100111,
    OPC_BRANCH    = 7'b1100011,
    OPC_LOAD      = 7'b0000011,
    OPC_STORE     = 7'b0100011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_OP_32     = 7'b0111011
  } opcode_t;

  // branch compare kinds
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // load/store access size, u = zero extended
  localparam logic [2:0] F3_MEM_B  = 3'b000;
  localparam logic [2:0] F3_MEM_H  = 3'b001;
  localparam logic [2:0] F3_MEM_W  = 3'b010;
  localparam logic [2:0] F3_MEM_D  = 3'b011;
  localparam logic [2:0] F3_MEM_BU = 3'b100;
  localparam logic [2:0] F3_MEM_HU = 3'b101;
  localparam logic [2:0] F3_MEM_WU = 3'b110;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one word, six encodings
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# compile and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_id_stage -f build.f -o sim_id_stage

./obj_dir/sim_id_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test passed$" sim.log; then
  exit 0
else
  exit 1
fi

/* verification/tb_ref_model.svh */
// reference decode, immediate, alu op, branch condition and target functions
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic logic [63:0] ref_imm(input logic [31:0] w);
  case (w[6:0])
    OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM_32: return {{52{w[31]}}, w[31:20]};
    OPC_STORE:            return {{52{w[31]}}, w[31:25], w[11:7]};
    OPC_BRANCH:           return {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    OPC_LUI, OPC_AUIPC:   return {{32{w[31]}}, w[31:12], 12'h000};
    OPC_JAL:              return {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    default:              return 64'h0;
  endcase
endfunction

function automatic logic ref_uses_rs1(input logic [31:0] w);
  return w[6:0] inside {OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM,
                        OPC_OP_IMM_32, OPC_OP, OPC_OP_32};
endfunction

function automatic logic ref_uses_rs2(input logic [31:0] w);
  return w[6:0] inside {OPC_BRANCH, OPC_STORE, OPC_OP, OPC_OP_32};
endfunction

// register ops use funct7 bit 30 for sub, both kinds use it for sra
function automatic alu_op_t ref_alu_op(input logic [31:0] w);
  logic reg_op;
  reg_op = (w[6:0] == OPC_OP) || (w[6:0] == OPC_OP_32);
  if (!(reg_op || w[6:0] == OPC_OP_IMM || w[6:0] == OPC_OP_IMM_32)) return ALU_ADD;
  case (w[14:12])
    3'b000:  return (reg_op && w[30]) ? ALU_SUB : ALU_ADD;
    3'b001:  return ALU_SLL;
    3'b010:  return ALU_SLT;
    3'b011:  return ALU_SLTU;
    3'b100:  return ALU_XOR;
    3'b101:  return w[30] ? ALU_SRA : ALU_SRL;
    3'b110:  return ALU_OR;
    default: return ALU_AND;
  endcase
endfunction

// {src1, src2[1:0], word, gpr_wen, mem_ren, mem_wen, mem_op[2:0], invalid}
function automatic logic [10:0] ref_ctrl(input logic [31:0] w);
  logic       s1;
  logic [1:0] s2;
  logic       word;
  logic       wen;
  logic       ren;
  logic       mwen;
  logic [2:0] mop;
  logic       inv;
  s1 = 1'b0;
  s2 = SRC2_RS2;
  word = 1'b0;
  wen = 1'b0;
  ren = 1'b0;
  mwen = 1'b0;
  mop = 3'b000;
  inv = 1'b0;
  case (w[6:0])
    OPC_LUI:       begin s2 = SRC2_IMM; wen = 1'b1; end
    OPC_AUIPC:     begin s1 = 1'b1; s2 = SRC2_IMM; wen = 1'b1; end
    OPC_JAL:       begin s1 = 1'b1; s2 = SRC2_FOUR; wen = 1'b1; end
    OPC_JALR:      begin s1 = 1'b1; s2 = SRC2_FOUR; wen = 1'b1; end
    OPC_BRANCH:    ;
    OPC_LOAD:      begin s2 = SRC2_IMM; wen = 1'b1; ren = 1'b1; mop = w[14:12]; end
    OPC_STORE:     begin s2 = SRC2_IMM; mwen = 1'b1; mop = w[14:12]; end
    OPC_OP_IMM:    begin s2 = SRC2_IMM; wen = 1'b1; end
    OPC_OP_IMM_32: begin s2 = SRC2_IMM; wen = 1'b1; word = 1'b1; end
    OPC_OP:        wen = 1'b1;
    OPC_OP_32:     begin wen = 1'b1; word = 1'b1; end
    default:       inv = 1'b1;
  endcase
  return {s1, s2, word, wen, ren, mwen, mop, inv};
endfunction

function automatic logic ref_cond(input logic [31:0] w, input logic [63:0] a,
                                  input logic [63:0] b);
  if (w[6:0] == OPC_JAL || w[6:0] == OPC_JALR) return 1'b1;
  if (w[6:0] != OPC_BRANCH) return 1'b0;
  case (w[14:12])
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    3'b111:  return a >= b;
    default: return 1'b0;
  endcase
endfunction

function automatic logic [63:0] ref_target(input logic [31:0] w, input logic [63:0] pc,
                                           input logic [63:0] a);
  logic [63:0] t;
  if (w[6:0] == OPC_JALR) begin
    t = a + ref_imm(w);
    return {t[63:1], 1'b0};
  end
  return pc + ref_imm(w);
endfunction

`endif

/* verification/tb_id_stage.sv */
// testbench for the decode stage: stimulus, reference compare, hazard and stall checks
`timescale 1ns/1ps
`default_nettype none
`include "ds_params.svh"

module tb_id_stage;

  import rv_isa_pkg::*;
  import ds_ctrl_pkg::*;

  `include "tb_ref_model.svh"

  localparam int N_ALU  = 40;
  localparam int N_MISC = 40;
  localparam int N_BR   = 40;
  localparam int N_HAZ  = 11;
  localparam int N_BP   = 8;
  localparam int N_INST = N_ALU + N_MISC + N_BR + N_HAZ + N_BP;
  localparam int TIMEOUT_CYC = N_INST * 20 + 300; // includes reset and register fill

  logic                   i_clk;
  logic                   i_rst_n;
  logic                   i_fs_to_ds_valid;
  logic [`INST_W-1:0]     i_fs_inst;
  logic [`XLEN-1:0]       i_fs_pc;
  logic                   o_ds_allowin;
  logic                   i_es_allowin;
  logic                   o_ds_to_es_valid;
  logic [`XLEN-1:0]       o_pc;
  logic [`XLEN-1:0]       o_rs1_data;
  logic [`XLEN-1:0]       o_rs2_data;
  logic [`XLEN-1:0]       o_imm;
  logic [`GPR_AW-1:0]     o_rd;
  alu_op_t                o_alu_op;
  src1_sel_t              o_alu_src1_sel;
  src2_sel_t              o_alu_src2_sel;
  logic                   o_alu_word;
  logic                   o_gpr_wen;
  logic                   o_mem_ren;
  logic                   o_mem_wen;
  mem_op_t                o_mem_op;
  logic                   o_invalid_inst;
  logic                   o_br_taken;
  logic [`XLEN-1:0]       o_br_target;
  logic                   i_wb_gpr_wen;
  logic [`GPR_AW-1:0]     i_wb_gpr_waddr;
  logic [`XLEN-1:0]       i_wb_gpr_wdata;
  logic [`GPR_AW-1:0]     i_es_gpr_rd;
  logic [`GPR_AW-1:0]     i_ms_gpr_rd;
  logic [`GPR_AW-1:0]     i_ws_gpr_rd;

  logic [63:0] gpr_model [32];
  logic [31:0] exp_inst [$]; // accepted, not yet passed to execute
  logic [63:0] exp_pc [$];
  logic [63:0] pc_next;
  int          errors;
  int          issued;
  int          passed;
  int          squashed;

  id_stage id_stage_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  initial begin
    #(TIMEOUT_CYC * 10);
    $display("timeout: the stage stopped passing instructions to execute");
    $display("Test failed");
    $finish;
  end

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic ref_stall(input logic [31:0] w);
    logic [4:0] r1;
    logic [4:0] r2;
    logic       h1;
    logic       h2;
    r1 = w[19:15];
    r2 = w[24:20];
    h1 = ref_uses_rs1(w) && r1 != 0 &&
         (r1 == i_es_gpr_rd || r1 == i_ms_gpr_rd || r1 == i_ws_gpr_rd);
    h2 = ref_uses_rs2(w) && r2 != 0 &&
         (r2 == i_es_gpr_rd || r2 == i_ms_gpr_rd || r2 == i_ws_gpr_rd);
    return h1 || h2;
  endfunction

  function automatic logic [31:0] rand_word(input logic [6:0] opc);
    logic [31:0] w;
    w = $urandom();
    w[6:0] = opc;
    return w;
  endfunction

  // compares one instruction leaving for execute
  task automatic compare_out(input logic [31:0] w, input logic [63:0] pc);
    logic [63:0] a;
    logic [63:0] b;
    logic [10:0] got_ctrl;
    logic [10:0] exp_ctrl;
    logic        cond;
    a = ref_uses_rs1(w) ? gpr_model[w[19:15]] : 64'h0;
    b = ref_uses_rs2(w) ? gpr_model[w[24:20]] : 64'h0;
    got_ctrl = {o_alu_src1_sel, o_alu_src2_sel, o_alu_word, o_gpr_wen, o_mem_ren,
                o_mem_wen, o_mem_op, o_invalid_inst};
    exp_ctrl = ref_ctrl(w);
    cond = ref_cond(w, a, b);
    check("pc", o_pc, pc);
    check("rs1 data", o_rs1_data, a);
    check("rs2 data", o_rs2_data, b);
    check("imm", o_imm, ref_imm(w));
    check("rd", o_rd, exp_ctrl[6] ? w[11:7] : 5'd0);
    check("alu op", o_alu_op, ref_alu_op(w));
    check("ctrl", got_ctrl, exp_ctrl);
    check("br taken", o_br_taken, cond);
    if (cond) check("br target", o_br_target, ref_target(w, pc, a));
  endtask

  // sampled on the falling edge, inputs settle 1 ns after the rising edge
  initial begin
    logic        held;
    logic        haz;
    logic        hs;
    logic        hold_prev;
    logic [63:0] snap [4];
    hold_prev = 1'b0;
    forever begin
      @(negedge i_clk);
      if (!i_rst_n) continue;
      held = exp_inst.size() > 0;
      haz  = held && ref_stall(exp_inst[0]);
      if (hold_prev) begin
        check("held pc", o_pc, snap[0]);
        check("held imm", o_imm, snap[1]);
        check("held rs1 data", o_rs1_data, snap[2]);
        check("held rs2 data", o_rs2_data, snap[3]);
      end
      check("ds_to_es_valid", o_ds_to_es_valid, held && !haz);
      check("ds_allowin", o_ds_allowin, !held || (!haz && i_es_allowin));
      hs = o_ds_to_es_valid && i_es_allowin;
      if (hs) begin
        compare_out(exp_inst[0], exp_pc[0]);
        void'(exp_inst.pop_front());
        void'(exp_pc.pop_front());
        passed++;
      end else begin
        check("br taken while not leaving", o_br_taken, 1'b0);
      end
      hold_prev = held && !hs;
      snap[0] = o_pc;
      snap[1] = o_imm;
      snap[2] = o_rs1_data;
      snap[3] = o_rs2_data;
      if (i_fs_to_ds_valid && o_ds_allowin) begin
        if (o_br_taken) begin
          squashed++;
        end else begin
          exp_inst.push_back(i_fs_inst);
          exp_pc.push_back(i_fs_pc);
        end
      end
    end
  end

  task automatic offer(input logic [31:0] w);
    i_fs_to_ds_valid = 1'b1;
    i_fs_inst = w;
    i_fs_pc = pc_next;
    @(negedge i_clk);
    while (!o_ds_allowin) @(negedge i_clk);
    @(posedge i_clk);
    #1;
    i_fs_to_ds_valid = 1'b0;
    pc_next += 4;
    issued++;
  endtask

  task automatic write_back(input logic [4:0] addr, input logic [63:0] data);
    i_wb_gpr_wen = 1'b1;
    i_wb_gpr_waddr = addr;
    i_wb_gpr_wdata = data;
    @(posedge i_clk);
    #1;
    i_wb_gpr_wen = 1'b0;
    if (addr != 0) gpr_model[addr] = data;
  endtask

  // one source register matched in one later stage, then released
  task automatic stall_on(input int stage, input logic [31:0] w, input logic [4:0] r);
    // previous instruction gone first
    @(negedge i_clk);
    while (o_ds_to_es_valid || !o_ds_allowin) @(negedge i_clk);
    @(posedge i_clk);
    #1;
    case (stage)
      0:       i_es_gpr_rd = r;
      1:       i_ms_gpr_rd = r;
      default: i_ws_gpr_rd = r;
    endcase
    offer(w);
    repeat (4) @(posedge i_clk);
    #1;
    i_es_gpr_rd = '0;
    i_ms_gpr_rd = '0;
    i_ws_gpr_rd = '0;
  endtask

  initial begin
    logic [6:0]  misc_opc [8];
    logic [31:0] w;
    misc_opc = '{OPC_LOAD, OPC_STORE, OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                 7'b1110011, 7'b0000000};
    void'($urandom(32'h05e8_46bc));
    errors = 0;
    issued = 0;
    passed = 0;
    squashed = 0;
    pc_next = 64'h0000_0000_8000_0000;
    i_rst_n = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_fs_inst = '0;
    i_fs_pc = '0;
    i_es_allowin = 1'b1;
    i_wb_gpr_wen = 1'b0;
    i_wb_gpr_waddr = '0;
    i_wb_gpr_wdata = '0;
    i_es_gpr_rd = '0;
    i_ms_gpr_rd = '0;
    i_ws_gpr_rd = '0;
    for (int i = 0; i < 32; i++) gpr_model[i] = 64'h0;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    for (int i = 0; i < 32; i++) write_back(i[4:0], {$urandom(), $urandom()});
    // register and immediate arithmetic
    for (int i = 0; i < N_ALU; i++) begin
      case (i % 4)
        0:       offer(rand_word(OPC_OP));
        1:       offer(rand_word(OPC_OP_IMM));
        2:       offer(rand_word(OPC_OP_32));
        default: offer(rand_word(OPC_OP_IMM_32));
      endcase
    end
    // memory, upper immediates, jumps and unsupported opcodes
    for (int i = 0; i < N_MISC; i++) offer(rand_word(misc_opc[i % 8]));
    // branches, every fourth compares a register with itself
    for (int i = 0; i < N_BR; i++) begin
      w = rand_word(OPC_BRANCH);
      if (i % 4 == 0) w[24:20] = w[19:15];
      offer(w);
    end
    // read-after-write interlock
    for (int i = 0; i < 6; i++) begin
      w = rand_word(OPC_OP);
      w[19:15] = 5'd5 + i[4:0];
      w[24:20] = 5'd12 + i[4:0];
      stall_on(i % 3, w, (i < 3) ? w[19:15] : w[24:20]);
    end
    w = rand_word(OPC_LUI);
    w[19:15] = 5'd3;
    stall_on(0, w, w[19:15]); // unused source
    w = rand_word(OPC_OP_IMM);
    w[24:20] = 5'd4;
    stall_on(1, w, w[24:20]); // immediate op has no rs2
    w = rand_word(OPC_OP);
    w[19:15] = 5'd0;
    w[24:20] = 5'd0;
    stall_on(2, w, 5'd0);
    w = rand_word(OPC_JALR);
    w[19:15] = 5'd9;
    stall_on(0, w, w[19:15]); // stalled jump must not redirect
    w = rand_word(OPC_STORE);
    stall_on(2, w, w[24:20]);
    // back-pressure from execute, one jump held in the stage
    i_es_allowin = 1'b0;
    fork
      for (int i = 0; i < N_BP; i++) offer(rand_word((i == 3) ? OPC_JAL : OPC_OP_IMM));
      for (int i = 0; i < N_BP; i++) begin
        repeat (3) @(posedge i_clk);
        #1;
        i_es_allowin = 1'b1;
        @(posedge i_clk);
        #1;
        i_es_allowin = 1'b0;
      end
    join
    i_es_allowin = 1'b1;
    while (exp_inst.size() > 0) @(negedge i_clk);
    repeat (2) @(posedge i_clk);
    if (passed + squashed != issued) begin
      errors++;
      $display("instruction count mismatch: issued %0d, passed %0d, squashed %0d",
               issued, passed, squashed);
    end
    $display("errors: %0d, issued %0d, passed %0d, squashed %0d",
             errors, issued, passed, squashed);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
